//--- rtl/decode_consts.svh
// Widths and encodings of the decode stage instruction set
// Opcode values are 7 bits and function codes 4 bits wide
// Register 31 is the stack pointer alias, banked above register 31
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// Word and field widths
`define INSTR_W         32
`define IMM_W           32
`define AREG_W          6

// ==============================
// Opcodes
// ==============================
`define OP_R2           7'h02
`define OP_ADDI         7'h04
`define OP_ANDI         7'h08
`define OP_ORI          7'h09
`define OP_LOAD         7'h40
`define OP_LOADZ        7'h41
`define OP_STORE        7'h48
`define OP_LDA          7'h4A
`define OP_BEQ          7'h26
`define OP_BNE          7'h27
`define OP_BSR          7'h20
`define OP_JSRI         7'h21
`define OP_NOP          7'h7F
`define OP_BRK          7'h00
`define OP_FENCE        7'h7A
`define OP_CSR          7'h07
`define OP_RTI          7'h78
`define OP_PFX          7'h7C

// R2 function codes in the low bits of imm10
`define FN_ADD          4'h0
`define FN_SUB          4'h1
`define FN_AND          4'h2
`define FN_OR           4'h3
`define FN_XOR          4'h4
`define FN_MUL          4'h8
`define FN_MULU         4'h9
`define FN_DIV          4'hA
`define FN_DIVU         4'hB

// Stack pointer banking
`define SP_ALIAS        31
`define SP_BANK_BASE    32

`endif

//--- rtl/decode_pkg.sv
// Types shared by the decode stage and its testbench
// Field order inside the structs sets the packed bit layout of the decode bus
`include "decode_consts.svh"

package decode_pkg;

	// ==============================
	// Plain vector types
	// ==============================
	typedef logic [`INSTR_W-1:0] instrWord;
	typedef logic [`IMM_W-1:0]   immVal;
	typedef logic [`AREG_W-1:0]  aReg;

	// Operating mode also selects the banked stack pointer
	typedef enum logic [1:0] {
		MODE_USER    = 2'd0,
		MODE_SUPER   = 2'd1,
		MODE_HYPER   = 2'd2,
		MODE_MACHINE = 2'd3
	} operatingMode;

	// Current instruction and the word that follows it in the fetch stream
	typedef struct packed {
		instrWord ins;
		instrWord nxt;
	} fetchPair;

	// One-hot operation class with exactly one flag set per instruction
	typedef struct packed {
		logic alu;
		logic mul;
		logic mulu;
		logic div;
		logic divu;
		logic load;
		logic loadz;
		logic store;
		logic lda;
		logic branch;
		logic bsr;
		logic jsri;
		logic nop;
		logic brk;
		logic fence;
		logic csr;
		logic rti;
		logic pfx;
	} opClass;

	// ==============================
	// Decode bus of 79 bits
	// ==============================
	typedef struct packed {
		logic   v;
		immVal  imm;
		logic   hasImm;
		aReg    ra;
		aReg    rb;
		aReg    rt;
		logic   raz;
		logic   rbz;
		logic   rtz;
		logic   rav;
		logic   rbv;
		logic   rtv;
		opClass cls;
		logic   mem;
		logic   sync;
		logic   multicycle;
	} decodeBus;

endpackage

//--- rtl/imm_decoder.sv
// Combinational immediate builder
// A PFX opcode in the following word supplies the upper 22 immediate bits
// Instructions without an immediate report zero
`include "decode_consts.svh"

module imm_decoder (
	input  decode_pkg::fetchPair instr,
	output decode_pkg::immVal    imm,
	output logic                 hasImm
);

	import decode_pkg::*;

	instrWord ins;
	instrWord nxt;
	logic     isPfx;
	logic [9:0] imm10;

	assign ins   = instr.ins;
	assign nxt   = instr.nxt;
	assign imm10 = ins[31:22];

	// The postfix is only recognised by its opcode in the next word
	assign isPfx = (nxt[6:0] == `OP_PFX);

	// Opcodes that carry an immediate in imm10
	always_comb begin
		case (ins[6:0])
			`OP_ADDI, `OP_ANDI, `OP_ORI:             hasImm = 1'b1;
			`OP_LOAD, `OP_LOADZ, `OP_STORE, `OP_LDA: hasImm = 1'b1;
			`OP_BEQ, `OP_BNE, `OP_BSR, `OP_JSRI:     hasImm = 1'b1;
			`OP_CSR:                                 hasImm = 1'b1;
			default:                                 hasImm = 1'b0;
		endcase
	end

	// ==============================
	// Immediate assembly
	// ==============================
	always_comb begin
		if (!hasImm) begin
			imm = '0;
		end
		else if (isPfx) begin
			// Postfix bits 28..7 sit directly above imm10
			imm = {nxt[28:7], imm10};
		end
		else begin
			// Short form is sign extended from bit 9
			imm = {{(`IMM_W-10){imm10[9]}}, imm10};
		end
	end

endmodule

//--- rtl/reg_decoder.sv
// Combinational register field decoder
// Field 31 selects one of four banked stack pointers, numbers 32 to 35
// Use flags depend on the opcode only, an unknown opcode reads no register
`include "decode_consts.svh"

module reg_decoder (
	input  decode_pkg::operatingMode om,
	input  decode_pkg::instrWord     instr,
	output decode_pkg::aReg          ra,
	output decode_pkg::aReg          rb,
	output decode_pkg::aReg          rt,
	output logic                     raz,
	output logic                     rbz,
	output logic                     rtz,
	output logic                     rav,
	output logic                     rbv,
	output logic                     rtv
);

	import decode_pkg::*;

	logic [4:0] fldA;
	logic [4:0] fldB;
	logic [4:0] fldT;

	// Map a 5-bit field to an architectural number
	function automatic aReg mapReg(input logic [4:0] fld, input operatingMode mode);
		if (fld == 5'(`SP_ALIAS))
			mapReg = aReg'(`SP_BANK_BASE) + aReg'(mode);
		else
			mapReg = {1'b0, fld};
	endfunction

	assign fldT = instr[11:7];
	assign fldA = instr[16:12];
	assign fldB = instr[21:17];

	// ==============================
	// Numbers and zero flags
	// ==============================
	assign ra = mapReg(fldA, om);
	assign rb = mapReg(fldB, om);
	assign rt = mapReg(fldT, om);

	// Zero flags look at the raw field before banking
	assign raz = (fldA == 5'd0);
	assign rbz = (fldB == 5'd0);
	assign rtz = (fldT == 5'd0);

	// Use flags
	always_comb begin
		rav = 1'b0;
		rbv = 1'b0;
		rtv = 1'b0;
		case (instr[6:0])
			`OP_R2: begin
				rav = 1'b1;
				rbv = 1'b1;
				rtv = 1'b1;
			end
			`OP_ADDI, `OP_ANDI, `OP_ORI, `OP_LOAD, `OP_LOADZ, `OP_LDA, `OP_JSRI, `OP_CSR: begin
				rav = 1'b1;
				rtv = 1'b1;
			end
			// Store data is read through rb and nothing is written
			`OP_STORE, `OP_BEQ, `OP_BNE: begin
				rav = 1'b1;
				rbv = 1'b1;
			end
			// BSR leaves rtv clear since the link write happens elsewhere
			default: begin
				rav = 1'b0;
			end
		endcase
	end

endmodule

//--- rtl/class_decoder.sv
// Combinational operation class decoder
// Produces one-hot class flags, an unknown opcode decodes as a nop
// R2 functions outside the multiply and divide group are plain ALU ops
`include "decode_consts.svh"

module class_decoder (
	input  decode_pkg::instrWord instr,
	output decode_pkg::opClass   cls,
	output logic                 multicycle
);

	logic [6:0] opcode;
	logic [3:0] func;

	assign opcode = instr[6:0];
	// Function code lives in the low bits of imm10
	assign func   = instr[25:22];

	// ==============================
	// Class decode
	// ==============================
	always_comb begin
		cls        = '0;
		multicycle = 1'b0;
		case (opcode)
			`OP_R2: begin
				case (func)
					`FN_MUL: begin
						cls.mul    = 1'b1;
						multicycle = 1'b1;
					end
					`FN_MULU: begin
						cls.mulu   = 1'b1;
						multicycle = 1'b1;
					end
					`FN_DIV: begin
						cls.div    = 1'b1;
						multicycle = 1'b1;
					end
					`FN_DIVU: begin
						cls.divu   = 1'b1;
						multicycle = 1'b1;
					end
					`FN_ADD, `FN_SUB, `FN_AND, `FN_OR, `FN_XOR: cls.alu = 1'b1;
					// Reserved functions still go to the ALU
					default: cls.alu = 1'b1;
				endcase
			end
			`OP_ADDI, `OP_ANDI, `OP_ORI: cls.alu = 1'b1;
			`OP_LOAD:  cls.load  = 1'b1;
			`OP_LOADZ: cls.loadz = 1'b1;
			`OP_STORE: cls.store = 1'b1;
			`OP_LDA:   cls.lda   = 1'b1;
			`OP_BEQ, `OP_BNE: cls.branch = 1'b1;
			`OP_BSR:   cls.bsr   = 1'b1;
			`OP_JSRI:  cls.jsri  = 1'b1;
			`OP_NOP:   cls.nop   = 1'b1;
			`OP_BRK:   cls.brk   = 1'b1;
			// A fence stalls until older work drains
			`OP_FENCE: begin
				cls.fence  = 1'b1;
				multicycle = 1'b1;
			end
			`OP_CSR:   cls.csr   = 1'b1;
			`OP_RTI:   cls.rti   = 1'b1;
			`OP_PFX:   cls.pfx   = 1'b1;
			default:   cls.nop   = 1'b1;
		endcase
	end

endmodule

//--- rtl/instr_decoder.sv
// Decode stage top level with one cycle of latency
// Inputs are captured on a rising edge while en is high, dbo holds otherwise
// Reset leaves a nop on the bus with v clear
`include "decode_consts.svh"

module instr_decoder (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     en,
	input  decode_pkg::operatingMode om,
	input  decode_pkg::fetchPair     instr,
	output decode_pkg::decodeBus     dbo
);

	import decode_pkg::*;

	decodeBus db;
	immVal    imm;
	logic     hasImm;
	aReg      ra;
	aReg      rb;
	aReg      rt;
	logic     raz;
	logic     rbz;
	logic     rtz;
	logic     rav;
	logic     rbv;
	logic     rtv;
	opClass   cls;
	logic     multicycle;

	// ==============================
	// Sub-decoders
	// ==============================
	imm_decoder uImm (
		.instr  (instr),
		.imm    (imm),
		.hasImm (hasImm)
	);

	reg_decoder uReg (
		.om    (om),
		.instr (instr.ins),
		.ra    (ra),
		.rb    (rb),
		.rt    (rt),
		.raz   (raz),
		.rbz   (rbz),
		.rtz   (rtz),
		.rav   (rav),
		.rbv   (rbv),
		.rtv   (rtv)
	);

	class_decoder uCls (
		.instr      (instr.ins),
		.cls        (cls),
		.multicycle (multicycle)
	);

	// Merge the sub-decoder results and add the derived flags
	always_comb begin
		db.v          = 1'b1;
		db.imm        = imm;
		db.hasImm     = hasImm;
		db.ra         = ra;
		db.rb         = rb;
		db.rt         = rt;
		db.raz        = raz;
		db.rbz        = rbz;
		db.rtz        = rtz;
		db.rav        = rav;
		db.rbv        = rbv;
		db.rtv        = rtv;
		db.cls        = cls;
		db.multicycle = multicycle;
		db.mem        = cls.load | cls.loadz | cls.store;
		// Only a fence with every imm10 bit set is a full synchronising fence
		db.sync       = cls.fence && (instr.ins[31:22] == 10'h3FF);
	end

	// ==============================
	// Output register
	// ==============================
	always_ff @(posedge clk) begin
		if (rst) begin
			dbo         <= '0;
			dbo.cls.nop <= 1'b1;
		end
		else if (en) begin
			dbo <= db;
		end
	end

endmodule

//--- tests/tb_decoder.sv
// Decode stage testbench driven by the trace in tests/decode_trace.txt
// The trace path is relative to the project root, so run from there
// Inputs change on the falling edge and dbo is sampled on a later falling edge
module tb_decoder;

	timeunit 1ns;
	timeprecision 1ps;

	import decode_pkg::*;

	localparam string TRACE_PATH = "tests/decode_trace.txt";

	logic         clk;
	logic         rst;
	logic         en;
	operatingMode om;
	fetchPair     instr;
	decodeBus     dbo;

	// One entry per trace line
	operatingMode traceOm  [$];
	fetchPair     traceIn  [$];
	decodeBus     traceExp [$];

	logic [31:0] lcgState;
	int          cycles;
	int          cycleLimit;
	int          fieldErrs;
	int          passCount;
	int          failCount;

	instr_decoder dut (
		.clk   (clk),
		.rst   (rst),
		.en    (en),
		.om    (om),
		.instr (instr),
		.dbo   (dbo)
	);

	// 20 ns clock period
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// The watchdog limit stays zero until the trace has been read
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycleLimit > 0 && cycles >= cycleLimit) begin
			$display("Timeout: run stopped after %0d cycles before all tests finished", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	// ==============================
	// Helpers
	// ==============================
	// Linear congruential step for the idle gaps and the junk inputs
	function automatic logic [31:0] nextRandom(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic reportField(input int n, input string ph, input string name,
			input logic [31:0] got, input logic [31:0] exp);
		$display("[ERROR] %0t test %0d %s: %s is %h, expected %h", $time, n, ph, name, got, exp);
		fieldErrs++;
	endtask

	// Field by field compare of dbo against the expected bus
	task automatic compareBus(input int n, input string ph, input decodeBus e);
		if (dbo.v !== e.v) reportField(n, ph, "v", dbo.v, e.v);
		if (dbo.imm !== e.imm) reportField(n, ph, "imm", dbo.imm, e.imm);
		if (dbo.hasImm !== e.hasImm) reportField(n, ph, "hasImm", dbo.hasImm, e.hasImm);
		if (dbo.ra !== e.ra) reportField(n, ph, "ra", dbo.ra, e.ra);
		if (dbo.rb !== e.rb) reportField(n, ph, "rb", dbo.rb, e.rb);
		if (dbo.rt !== e.rt) reportField(n, ph, "rt", dbo.rt, e.rt);
		if (dbo.raz !== e.raz) reportField(n, ph, "raz", dbo.raz, e.raz);
		if (dbo.rbz !== e.rbz) reportField(n, ph, "rbz", dbo.rbz, e.rbz);
		if (dbo.rtz !== e.rtz) reportField(n, ph, "rtz", dbo.rtz, e.rtz);
		if (dbo.rav !== e.rav) reportField(n, ph, "rav", dbo.rav, e.rav);
		if (dbo.rbv !== e.rbv) reportField(n, ph, "rbv", dbo.rbv, e.rbv);
		if (dbo.rtv !== e.rtv) reportField(n, ph, "rtv", dbo.rtv, e.rtv);
		if (dbo.cls !== e.cls) reportField(n, ph, "cls", dbo.cls, e.cls);
		if (dbo.mem !== e.mem) reportField(n, ph, "mem", dbo.mem, e.mem);
		if (dbo.sync !== e.sync) reportField(n, ph, "sync", dbo.sync, e.sync);
		if (dbo.multicycle !== e.multicycle)
			reportField(n, ph, "multicycle", dbo.multicycle, e.multicycle);
	endtask

	// Closes a test and prints its one result line
	task automatic tallyTest(input int n);
		if (fieldErrs == 0) begin
			passCount++;
			$display("Test %0d: pass", n);
		end
		else begin
			failCount++;
			$display("Test %0d: FAIL with %0d field errors", n, fieldErrs);
		end
		fieldErrs = 0;
	endtask

	// ==============================
	// Main sequence
	// ==============================
	initial begin
		int          fd;
		int          lineNo;
		int          got;
		int          gap;
		logic        badTrace;
		string       line;
		logic [31:0] c [0:18];
		decodeBus    e;
		decodeBus    resetVal;

		rst        = 1'b1;
		en         = 1'b0;
		om         = MODE_USER;
		instr      = '0;
		cycles     = 0;
		cycleLimit = 0;
		fieldErrs  = 0;
		passCount  = 0;
		failCount  = 0;
		lineNo     = 0;
		badTrace   = 1'b0;
		lcgState   = 32'h93bc_f922;

		fd = $fopen(TRACE_PATH, "r");
		if (fd == 0) begin
			$display("Could not open the trace file %s", TRACE_PATH);
			badTrace = 1'b1;
		end
		// Lines starting with # are column notes
		while (fd != 0 && !$feof(fd)) begin
			line = "";
			got = $fgets(line, fd);
			lineNo++;
			if (got == 0 || line.len() < 2 || line.getc(0) == "#")
				continue;
			got = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				c[0], c[1], c[2], c[3], c[4], c[5], c[6], c[7], c[8], c[9],
				c[10], c[11], c[12], c[13], c[14], c[15], c[16], c[17], c[18]);
			if (got != 19) begin
				$display("Trace line %0d is unreadable, %0d of 19 columns found", lineNo, got);
				badTrace = 1'b1;
			end
			else begin
				// Column order matches the field order of decodeBus
				e = {c[3][0], c[4], c[5][0], c[6][5:0], c[7][5:0], c[8][5:0],
					c[9][0], c[10][0], c[11][0], c[12][0], c[13][0], c[14][0],
					c[15][17:0], c[16][0], c[17][0], c[18][0]};
				traceOm.push_back(operatingMode'(c[0][1:0]));
				traceIn.push_back({c[1], c[2]});
				traceExp.push_back(e);
			end
		end
		if (fd != 0)
			$fclose(fd);
		if (badTrace || traceExp.size() == 0) begin
			$display("The trace file holds no usable tests");
			$display("Simulation failed");
			$finish;
		end
		else begin
			cycleLimit = 4 * traceExp.size() + 50;

			// Four cycles of reset, then the reset value is checked as test 0
			repeat (4) @(posedge clk);
			@(negedge clk);
			rst = 1'b0;
			resetVal = '0;
			resetVal.cls.nop = 1'b1;
			compareBus(0, "reset", resetVal);
			tallyTest(0);

			for (int i = 0; i < traceExp.size(); i++) begin
				om    = traceOm[i];
				instr = traceIn[i];
				en    = 1'b1;
				@(negedge clk);
				compareBus(i + 1, "decode", traceExp[i]);
				// Scramble the inputs while en is low so that dbo must hold
				en = 1'b0;
				lcgState = nextRandom(lcgState);
				gap = int'(lcgState[31:30]);
				om = operatingMode'(lcgState[29:28]);
				lcgState = nextRandom(lcgState);
				instr.ins = lcgState;
				lcgState = nextRandom(lcgState);
				instr.nxt = lcgState;
				repeat (gap + 1) @(negedge clk);
				compareBus(i + 1, "hold", traceExp[i]);
				tallyTest(i + 1);
			end

			$display("Tests run: %0d, passed: %0d, failed: %0d",
				passCount + failCount, passCount, failCount);
			if (failCount == 0)
				$display("Simulation passed");
			else
				$display("Simulation failed");
			$finish;
		end
	end

endmodule

//--- tests/decode_trace.txt
# om ins nxt, then expected: v imm hasImm ra rb rt raz rbz rtz rav rbv rtv cls mem sync multicycle
# All columns hex, cls is the 18-bit opClass vector with alu at bit 17 and pfx at bit 0
0 00041182 e091a2fc 1 00000000 0 01 02 03 0 0 0 1 1 1 20000 0 0 0
0 00441182 0000007f 1 00000000 0 01 02 03 0 0 0 1 1 1 20000 0 0 0
0 00841182 0000007f 1 00000000 0 01 02 03 0 0 0 1 1 1 20000 0 0 0
0 00c41182 0000007f 1 00000000 0 01 02 03 0 0 0 1 1 1 20000 0 0 0
0 01041182 0000007f 1 00000000 0 01 02 03 0 0 0 1 1 1 20000 0 0 0
0 02041182 0000007f 1 00000000 0 01 02 03 0 0 0 1 1 1 10000 0 0 1
0 02441182 0000007f 1 00000000 0 01 02 03 0 0 0 1 1 1 08000 0 0 1
0 02841182 0000007f 1 00000000 0 01 02 03 0 0 0 1 1 1 04000 0 0 1
0 02c41182 0000007f 1 00000000 0 01 02 03 0 0 0 1 1 1 02000 0 0 1
0 fc041184 0000007f 1 fffffff0 1 01 02 03 0 0 0 1 0 1 20000 0 0 0
0 1ec41184 0000007f 1 0000007b 1 01 02 03 0 0 0 1 0 1 20000 0 0 0
0 fc041184 e091a2fc 1 048d17f0 1 01 02 03 0 0 0 1 0 1 20000 0 0 0
0 55441188 0000007f 1 00000155 1 01 02 03 0 0 0 1 0 1 20000 0 0 0
0 80041189 0000007f 1 fffffe00 1 01 02 03 0 0 0 1 0 1 20000 0 0 0
0 040411c0 0000007f 1 00000010 1 01 02 03 0 0 0 1 0 1 01000 1 0 0
0 040411c1 0000007f 1 00000010 1 01 02 03 0 0 0 1 0 1 00800 1 0 0
0 020411c8 0000007f 1 00000008 1 01 02 03 0 0 0 1 1 0 00400 1 0 0
0 ffc411ca 0000007f 1 ffffffff 1 01 02 03 0 0 0 1 0 1 00200 0 0 0
0 010411a6 0000007f 1 00000004 1 01 02 03 0 0 0 1 1 0 00100 0 0 0
0 ff0411a7 0000007f 1 fffffffc 1 01 02 03 0 0 0 1 1 0 00100 0 0 0
0 400411a0 0000007f 1 00000100 1 01 02 03 0 0 0 0 0 0 00080 0 0 0
0 000411a1 0000007f 1 00000000 1 01 02 03 0 0 0 1 0 1 00040 0 0 0
0 000411ff 0000007f 1 00000000 0 01 02 03 0 0 0 0 0 0 00020 0 0 0
0 00041180 0000007f 1 00000000 0 01 02 03 0 0 0 0 0 0 00010 0 0 0
0 ffc411fa 0000007f 1 00000000 0 01 02 03 0 0 0 0 0 0 00008 0 1 1
0 004411fa 0000007f 1 00000000 0 01 02 03 0 0 0 0 0 0 00008 0 0 1
0 30041187 0000007f 1 000000c0 1 01 02 03 0 0 0 1 0 1 00004 0 0 0
0 000411f8 0000007f 1 00000000 0 01 02 03 0 0 0 0 0 0 00002 0 0 0
0 000411fc 0000007f 1 00000000 0 01 02 03 0 0 0 0 0 0 00001 0 0 0
0 000411d5 0000007f 1 00000000 0 01 02 03 0 0 0 0 0 0 00020 0 0 0
0 003fff82 0000007f 1 00000000 0 20 20 20 0 0 0 1 1 1 20000 0 0 0
1 003fff82 0000007f 1 00000000 0 21 21 21 0 0 0 1 1 1 20000 0 0 0
2 003fff82 0000007f 1 00000000 0 22 22 22 0 0 0 1 1 1 20000 0 0 0
3 003fff82 0000007f 1 00000000 0 23 23 23 0 0 0 1 1 1 20000 0 0 0
0 00000002 0000007f 1 00000000 0 00 00 00 1 1 1 1 1 1 20000 0 0 0
2 fe0bf048 0000007f 1 fffffff8 1 22 05 00 0 0 1 1 1 0 00400 1 0 0

//--- files.f
+incdir+rtl
rtl/decode_pkg.sv
rtl/imm_decoder.sv
rtl/reg_decoder.sv
rtl/class_decoder.sv
rtl/instr_decoder.sv
tests/tb_decoder.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the decode stage testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal -f files.f \
	--top-module tb_decoder -o tb_decoder > build.log 2>&1 \
	&& ./obj_dir/tb_decoder > sim.log 2>&1 \
	|| { echo "Build or run failed"; cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "^Simulation passed$" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
